/* hw/ice_bus_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_bus_controller (
	input  logic                                clk,
	input  logic                                byte_counter_reset,

	// character device side
	input  logic [7:0]                          rx_char,
	input  logic                                rx_char_valid,
	output logic [7:0]                          tx_char,
	output logic                                tx_char_valid,
	input  logic                                tx_char_ready,

	// master-driven bus
	output logic [7:0]                          ma_data,
	output logic [7:0]                          ma_addr,
	output logic                                ma_data_valid,
	output logic                                ma_frame_valid,
	output logic [ice_bus_pkg::ICE_NUM_DEV-1:0] ma_arb_grant,
	input  logic                                sl_overflow,

	// slave return path
	input  logic [7:0]                          sl_data,
	input  logic [ice_bus_pkg::ICE_NUM_DEV-1:0] sl_arb_request,
	input  logic                                sl_data_valid,
	input  logic                                sl_frame_valid
);

	ice_bus_pkg::ice_bus_cmd_t    bus_cmd;
	ice_bus_pkg::ice_status_t     frame_status;
	ice_bus_pkg::ice_slave_beat_t slave_beat;
	logic                         abort;
	logic                         grant_enable;

	always_comb begin
		slave_beat.data_valid = sl_data_valid;
		slave_beat.frame_valid = sl_frame_valid;
		slave_beat.data = sl_data;
		slave_beat.spare = 1'b0;
	end

	ice_frame_decoder u_decoder (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.rx_char           (rx_char),
		.rx_char_valid     (rx_char_valid),
		.abort             (abort),
		.bus_cmd           (bus_cmd)
	);

	ice_bus_master u_master (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.bus_cmd           (bus_cmd),
		.sl_overflow       (sl_overflow),
		.ma_data           (ma_data),
		.ma_addr           (ma_addr),
		.ma_data_valid     (ma_data_valid),
		.ma_frame_valid    (ma_frame_valid),
		.abort             (abort),
		.frame_status      (frame_status)
	);

	ice_priority_select u_select (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.grant_enable      (grant_enable),
		.sl_arb_request    (sl_arb_request),
		.sl_frame_valid    (sl_frame_valid),
		.ma_arb_grant      (ma_arb_grant)
	);

	ice_reply_framer u_framer (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.frame_status      (frame_status),
		.slave_beat        (slave_beat),
		.ma_arb_grant      (ma_arb_grant),
		.tx_char_ready     (tx_char_ready),
		.tx_char           (tx_char),
		.tx_char_valid     (tx_char_valid),
		.grant_enable      (grant_enable)
	);

endmodule

`default_nettype wire

/* hw/ice_bus_master.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_bus_master (
	input  logic                      clk,
	input  logic                      byte_counter_reset,
	input  ice_bus_pkg::ice_bus_cmd_t bus_cmd,
	input  logic                      sl_overflow,
	output logic [7:0]                ma_data,
	output logic [7:0]                ma_addr,
	output logic                      ma_data_valid,
	output logic                      ma_frame_valid,
	output logic                      abort,
	output ice_bus_pkg::ice_status_t  frame_status
);

	logic [7:0] evt_id;
	logic       last_on_bus;
	logic       accept;
	logic       close_ack;
	logic       close_nak;

	// overflow only counts before the last byte has reached the bus.
	assign close_nak = ma_frame_valid && sl_overflow && !last_on_bus && !bus_cmd.last;
	assign close_ack = ma_frame_valid && (last_on_bus || (bus_cmd.last && !bus_cmd.valid));

	// An event id opens a frame, other bytes only extend an open one.
	// Bytes still in flight after an abort are dropped here.
	assign accept = bus_cmd.valid && (bus_cmd.first || (ma_frame_valid && !close_nak));

	always_ff @(posedge clk) begin
		if (accept)
			ma_data <= bus_cmd.data;
		if (accept && bus_cmd.first) begin
			ma_addr <= bus_cmd.addr;
			evt_id <= bus_cmd.data;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			ma_data_valid <= 1'b0;
			ma_frame_valid <= 1'b0;
			last_on_bus <= 1'b0;
			abort <= 1'b0;
			frame_status <= '0;
		end else begin
			ma_data_valid <= accept;
			last_on_bus <= accept && bus_cmd.last;
			abort <= close_nak;
			frame_status.valid <= close_ack || close_nak;
			frame_status.nak <= close_nak;
			frame_status.evt_id <= evt_id;
			if (close_ack || close_nak)
				ma_frame_valid <= 1'b0;
			else if (accept && bus_cmd.first)
				ma_frame_valid <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/ice_bus_pkg.sv */
`default_nettype none

package ice_bus_pkg;

	// slave population on the return path and the width of a device index.
	localparam int ICE_NUM_DEV = 2;
	localparam int ICE_DEV_W = 1;

	// the host length field is two bytes, so this is also the hard ceiling.
	localparam int ICE_MAX_PAYLOAD = 65535;
	localparam int ICE_LEN_W = $clog2(ICE_MAX_PAYLOAD + 1);

	// first byte of the status pair sent back to the host.
	localparam logic [7:0] ICE_ACK_CHAR = 8'h06;
	localparam logic [7:0] ICE_NAK_CHAR = 8'h15;

	// the transmit queue depth must stay a power of two.
	localparam int ICE_TX_DEPTH = 32;
	localparam int ICE_TX_AW = $clog2(ICE_TX_DEPTH);
	localparam int ICE_TX_CW = ICE_TX_AW + 1;

	// a slave frame takes its index, up to this many data bytes and a count byte.
	localparam int ICE_MAX_REPLY = 16;
	localparam logic [ICE_TX_CW-1:0] ICE_GRANT_ROOM = ICE_TX_CW'(ICE_MAX_REPLY + 2);

	typedef enum logic [2:0] {
		ICE_DEC_IDLE    = 3'd0,
		ICE_DEC_EVT     = 3'd1,
		ICE_DEC_LEN     = 3'd2,
		ICE_DEC_PYLD    = 3'd3,
		ICE_DEC_DISCARD = 3'd4
	} ice_dec_state_t;

	// one command per event id or payload byte.
	// last without valid is the end marker of a zero-length frame.
	typedef struct packed {
		logic       valid;
		logic       first;
		logic       last;
		logic [7:0] addr;
		logic [7:0] data;
	} ice_bus_cmd_t;

	typedef struct packed {
		logic       valid;
		logic       nak;
		logic [7:0] evt_id;
	} ice_status_t;

	typedef struct packed {
		logic       data_valid;
		logic       frame_valid;
		logic [7:0] data;
		logic       spare;
	} ice_slave_beat_t;

endpackage

`default_nettype wire

/* hw/ice_frame_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_frame_decoder (
	input  logic                      clk,
	input  logic                      byte_counter_reset,
	input  logic [7:0]                rx_char,
	input  logic                      rx_char_valid,
	input  logic                      abort,
	output ice_bus_pkg::ice_bus_cmd_t bus_cmd
);

	ice_bus_pkg::ice_dec_state_t state;

	logic [7:0]                        addr_q;
	logic [ice_bus_pkg::ICE_LEN_W-1:0] payload_len;
	logic [ice_bus_pkg::ICE_LEN_W-1:0] byte_counter;
	logic [ice_bus_pkg::ICE_LEN_W-1:0] len_next;
	logic [ice_bus_pkg::ICE_LEN_W-1:0] count_next;
	logic                              aborted;
	logic                              payload_done;

	// length arrives high byte first, so shift the low byte up.
	assign len_next = {payload_len[7:0], rx_char};
	assign count_next = byte_counter + (ice_bus_pkg::ICE_LEN_W)'(1);
	assign payload_done = (count_next == payload_len);

	always_ff @(posedge clk) begin
		if (rx_char_valid && state == ice_bus_pkg::ICE_DEC_IDLE)
			addr_q <= rx_char;
		if (rx_char_valid && state == ice_bus_pkg::ICE_DEC_LEN)
			payload_len <= len_next;
	end

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			state <= ice_bus_pkg::ICE_DEC_IDLE;
			byte_counter <= '0;
			aborted <= 1'b0;
			bus_cmd <= '0;
		end else begin
			bus_cmd.valid <= 1'b0;
			bus_cmd.first <= 1'b0;
			bus_cmd.last <= 1'b0;

			case (state)
				ice_bus_pkg::ICE_DEC_IDLE: begin
					aborted <= 1'b0;
					byte_counter <= '0;
					if (rx_char_valid)
						state <= ice_bus_pkg::ICE_DEC_EVT;
				end

				ice_bus_pkg::ICE_DEC_EVT: begin
					if (rx_char_valid) begin
						bus_cmd.valid <= 1'b1;
						bus_cmd.first <= 1'b1;
						bus_cmd.addr <= addr_q;
						bus_cmd.data <= rx_char;
						state <= ice_bus_pkg::ICE_DEC_LEN;
					end
				end

				// the bus frame is already open here, so an overflow may hit it.
				ice_bus_pkg::ICE_DEC_LEN: begin
					if (abort)
						aborted <= 1'b1;
					if (rx_char_valid) begin
						byte_counter <= count_next;
						if (byte_counter[0]) begin
							byte_counter <= '0;
							if (len_next == '0) begin
								// The event id went out before the length was known.
								// A zero-length frame is closed by a marker with no data.
								bus_cmd.last <= !(aborted || abort);
								state <= ice_bus_pkg::ICE_DEC_IDLE;
							end else if (aborted || abort) begin
								state <= ice_bus_pkg::ICE_DEC_DISCARD;
							end else begin
								state <= ice_bus_pkg::ICE_DEC_PYLD;
							end
						end
					end
				end

				ice_bus_pkg::ICE_DEC_PYLD: begin
					if (rx_char_valid) begin
						byte_counter <= count_next;
						if (!abort) begin
							bus_cmd.valid <= 1'b1;
							bus_cmd.addr <= addr_q;
							bus_cmd.data <= rx_char;
							bus_cmd.last <= payload_done;
						end
					end
					if (rx_char_valid && payload_done)
						state <= ice_bus_pkg::ICE_DEC_IDLE;
					else if (abort)
						state <= ice_bus_pkg::ICE_DEC_DISCARD;
				end

				// count off the rest of the payload without touching the bus.
				ice_bus_pkg::ICE_DEC_DISCARD: begin
					if (rx_char_valid) begin
						byte_counter <= count_next;
						if (payload_done)
							state <= ice_bus_pkg::ICE_DEC_IDLE;
					end
				end

				default: begin
					state <= ice_bus_pkg::ICE_DEC_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/ice_priority_select.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_priority_select (
	input  logic                                clk,
	input  logic                                byte_counter_reset,
	input  logic                                grant_enable,
	input  logic [ice_bus_pkg::ICE_NUM_DEV-1:0] sl_arb_request,
	input  logic                                sl_frame_valid,
	output logic [ice_bus_pkg::ICE_NUM_DEV-1:0] ma_arb_grant
);

	logic [ice_bus_pkg::ICE_NUM_DEV-1:0] lowest_request;
	logic                                frame_seen;
	logic                                release_gap;

	// two's complement leaves only the lowest set request bit.
	assign lowest_request = sl_arb_request &
		(~sl_arb_request + (ice_bus_pkg::ICE_NUM_DEV)'(1));

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			ma_arb_grant <= '0;
			frame_seen <= 1'b0;
			release_gap <= 1'b0;
		end else begin
			release_gap <= 1'b0;
			if (ma_arb_grant != '0) begin
				// hold until the granted frame has been up and come down again.
				if (sl_frame_valid) begin
					frame_seen <= 1'b1;
				end else if (frame_seen) begin
					ma_arb_grant <= '0;
					frame_seen <= 1'b0;
					release_gap <= 1'b1;
				end
			end else if (grant_enable && !release_gap) begin
				ma_arb_grant <= lowest_request;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/ice_reply_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_reply_framer (
	input  logic                                clk,
	input  logic                                byte_counter_reset,
	input  ice_bus_pkg::ice_status_t            frame_status,
	input  ice_bus_pkg::ice_slave_beat_t        slave_beat,
	input  logic [ice_bus_pkg::ICE_NUM_DEV-1:0] ma_arb_grant,
	input  logic                                tx_char_ready,
	output logic [7:0]                          tx_char,
	output logic                                tx_char_valid,
	output logic                                grant_enable
);

	logic [7:0]                        queue_mem [ice_bus_pkg::ICE_TX_DEPTH];
	logic [ice_bus_pkg::ICE_TX_AW-1:0] wr_ptr;
	logic [ice_bus_pkg::ICE_TX_AW-1:0] rd_ptr;
	logic [ice_bus_pkg::ICE_TX_CW-1:0] fill;
	logic [ice_bus_pkg::ICE_TX_CW-1:0] space;
	logic                              wr_en;
	logic                              rd_en;
	logic [7:0]                        wr_data;

	ice_bus_pkg::ice_slave_beat_t      beat_q;
	logic                              in_frame;
	logic                              frame_seen;
	logic [7:0]                        beat_count;
	logic [ice_bus_pkg::ICE_DEV_W-1:0] grant_index;
	logic                              grant_new;
	logic                              beat_wr;
	logic                              count_wr;

	logic                              pend_valid;
	logic                              pend_nak;
	logic [7:0]                        pend_evt;
	logic                              pair_phase;
	logic                              status_wr;

	assign space = (ice_bus_pkg::ICE_TX_CW)'(ice_bus_pkg::ICE_TX_DEPTH) - fill;
	assign tx_char_valid = (fill != '0);
	assign tx_char = queue_mem[rd_ptr];
	assign rd_en = tx_char_valid && tx_char_ready;

	always_comb begin
		grant_index = '0;
		for (int i = 0; i < ice_bus_pkg::ICE_NUM_DEV; i++)
			if (ma_arb_grant[i])
				grant_index = (ice_bus_pkg::ICE_DEV_W)'(i);
	end

	// slave beats are taken from the sampled copy that runs one cycle behind the grant.
	assign grant_new = (ma_arb_grant != '0) && !in_frame;
	assign beat_wr = in_frame && beat_q.frame_valid && beat_q.data_valid;
	assign count_wr = in_frame && frame_seen && !beat_q.frame_valid;

	// A status pair only goes in between slave frames.
	// The first byte also needs room for the second.
	assign status_wr = pend_valid && !in_frame && !grant_new &&
		(pair_phase ? (space != '0) : (space >= (ice_bus_pkg::ICE_TX_CW)'(2)));

	assign grant_enable = (space >= ice_bus_pkg::ICE_GRANT_ROOM) && !pend_valid &&
		!frame_status.valid && !in_frame;

	always_comb begin
		wr_en = 1'b1;
		wr_data = pend_evt;
		if (grant_new)
			wr_data = {{(8 - ice_bus_pkg::ICE_DEV_W){1'b0}}, grant_index};
		else if (beat_wr)
			wr_data = beat_q.data;
		else if (count_wr)
			wr_data = beat_count;
		else if (status_wr)
			wr_data = pair_phase ? pend_evt :
				(pend_nak ? ice_bus_pkg::ICE_NAK_CHAR : ice_bus_pkg::ICE_ACK_CHAR);
		else
			wr_en = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			queue_mem[wr_ptr] <= wr_data;
		if (frame_status.valid) begin
			pend_nak <= frame_status.nak;
			pend_evt <= frame_status.evt_id;
		end
		if (grant_new)
			beat_count <= '0;
		else if (beat_wr)
			beat_count <= beat_count + 8'd1;
	end

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			beat_q <= '0;
			in_frame <= 1'b0;
			frame_seen <= 1'b0;
			pend_valid <= 1'b0;
			pair_phase <= 1'b0;
		end else begin
			beat_q <= slave_beat;
			if (wr_en)
				wr_ptr <= wr_ptr + (ice_bus_pkg::ICE_TX_AW)'(1);
			if (rd_en)
				rd_ptr <= rd_ptr + (ice_bus_pkg::ICE_TX_AW)'(1);
			case ({wr_en, rd_en})
				2'b10: fill <= fill + (ice_bus_pkg::ICE_TX_CW)'(1);
				2'b01: fill <= fill - (ice_bus_pkg::ICE_TX_CW)'(1);
				default: fill <= fill;
			endcase

			if (grant_new)
				in_frame <= 1'b1;
			else if (count_wr)
				in_frame <= 1'b0;
			if (count_wr)
				frame_seen <= 1'b0;
			else if (in_frame && beat_q.frame_valid)
				frame_seen <= 1'b1;

			// a new status replaces the slot even while the old one finishes.
			if (frame_status.valid)
				pend_valid <= 1'b1;
			else if (status_wr && pair_phase)
				pend_valid <= 1'b0;
			if (status_wr)
				pair_phase <= !pair_phase;
		end
	end

endmodule

`default_nettype wire

/* ice_bus_controller.f */
+incdir+include
hw/ice_bus_pkg.sv
hw/ice_frame_decoder.sv
hw/ice_bus_master.sv
hw/ice_priority_select.sv
hw/ice_reply_framer.sv
hw/ice_bus_controller.sv
test/ice_bus_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f ice_bus_controller.f \
	--top-module ice_bus_controller_tb \
	-o ice_sim

./obj_dir/ice_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
	echo "simulation run: PASS"
else
	echo "simulation run: FAIL"
	exit 1
fi

/* include/ice_tb_model.svh */
`ifndef ICE_TB_MODEL_SVH
`define ICE_TB_MODEL_SVH

// bytes that the bus and the transmit port should show in order.
logic [7:0] bus_exp [$];
logic [7:0] bus_addr_exp;
logic [7:0] status_exp [$];
logic [7:0] slave_exp [$];
int         slave_len [$];

// the transmit parser counts the bytes left in the current pair or slave frame.
int         tx_unit_left = 0;
logic       tx_in_slave = 1'b0;

task automatic check_value(input string what, input int expected, input int actual);
	if (expected != actual) begin
		$display("Error %s: expected %0h, actual %0h", what, expected, actual);
		abort_run();
	end
endtask

// the event id opens the bus frame and the status pair answers it.
task automatic expect_host_frame(input logic [7:0] addr, input logic [7:0] evt,
	input logic nak);
	bus_addr_exp = addr;
	bus_exp.push_back(evt);
	status_exp.push_back(nak ? ice_bus_pkg::ICE_NAK_CHAR : ice_bus_pkg::ICE_ACK_CHAR);
	status_exp.push_back(evt);
endtask

task automatic expect_bus_byte(input logic [7:0] data);
	bus_exp.push_back(data);
endtask

// a slave frame goes back as its index, its data and then a count of the data.
task automatic expect_slave_frame(input int index, input int data_len);
	slave_exp.push_back(8'(index));
	slave_len.push_back(data_len + 2);
endtask

task automatic expect_slave_byte(input logic [7:0] data);
	slave_exp.push_back(data);
endtask

task automatic expect_slave_count(input int data_len);
	slave_exp.push_back(8'(data_len));
endtask

// under fixed priority the lowest requesting index wins.
function automatic int expected_grant(input logic [ice_bus_pkg::ICE_NUM_DEV-1:0] req);
	int grant;
	grant = 0;
	for (int i = ice_bus_pkg::ICE_NUM_DEV - 1; i >= 0; i--)
		if (req[i])
			grant = 1 << i;
	return grant;
endfunction

// Device indexes are below the status characters, so the first byte of a unit
// tells a slave frame from a status pair.
task automatic check_tx_byte(input logic [7:0] data);
	if (tx_unit_left == 0 && int'(data) < ice_bus_pkg::ICE_NUM_DEV && slave_len.size() != 0) begin
		tx_unit_left = slave_len.pop_front();
		tx_in_slave = 1'b1;
	end else if (tx_unit_left == 0) begin
		tx_unit_left = 2;
		tx_in_slave = 1'b0;
	end
	if (tx_in_slave) begin
		tx_unit_left--;
		check_value("slave frame byte", int'(slave_exp.pop_front()), int'(data));
	end else if (status_exp.size() != 0) begin
		tx_unit_left--;
		check_value("status byte", int'(status_exp.pop_front()), int'(data));
	end else begin
		$display("Transmit byte %0h arrived while no reply was expected", data);
		abort_run();
	end
endtask

`endif

/* test/ice_bus_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ice_bus_controller_tb;

	localparam int HOST_FRAMES = 30;
	localparam int SLAVE_FRAMES = 12;
	localparam int MAX_HOST_LEN = 12;
	localparam int TIMEOUT_CYCLES = 200 * HOST_FRAMES + 300 * SLAVE_FRAMES;

	logic                                clk;
	logic                                byte_counter_reset;
	logic [7:0]                          rx_char;
	logic                                rx_char_valid;
	logic [7:0]                          tx_char;
	logic                                tx_char_valid;
	logic                                tx_char_ready;
	logic [7:0]                          ma_data;
	logic [7:0]                          ma_addr;
	logic                                ma_data_valid;
	logic                                ma_frame_valid;
	logic [ice_bus_pkg::ICE_NUM_DEV-1:0] ma_arb_grant;
	logic                                sl_overflow;
	logic [7:0]                          sl_data;
	logic [ice_bus_pkg::ICE_NUM_DEV-1:0] sl_arb_request;
	logic                                sl_data_valid;
	logic                                sl_frame_valid;

	integer random_seed = 32'hb03b;
	logic   reset_done = 1'b0;
	logic   frame_valid_q = 1'b0;
	int     slave_requested = 0;
	int     slave_finished = 0;
	int     cycle_count = 0;

	`include "ice_tb_model.svh"

	ice_bus_controller u_dut (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.rx_char           (rx_char),
		.rx_char_valid     (rx_char_valid),
		.tx_char           (tx_char),
		.tx_char_valid     (tx_char_valid),
		.tx_char_ready     (tx_char_ready),
		.ma_data           (ma_data),
		.ma_addr           (ma_addr),
		.ma_data_valid     (ma_data_valid),
		.ma_frame_valid    (ma_frame_valid),
		.ma_arb_grant      (ma_arb_grant),
		.sl_overflow       (sl_overflow),
		.sl_data           (sl_data),
		.sl_arb_request    (sl_arb_request),
		.sl_data_valid     (sl_data_valid),
		.sl_frame_valid    (sl_frame_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'({$random(random_seed)} % (hi - lo + 1));
	endfunction

	// all stimulus changes 1 ns after the rising edge.
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic send_host_byte(input logic [7:0] data);
		rx_char = data;
		rx_char_valid = 1'b1;
		next_cycle();
		rx_char_valid = 1'b0;
		repeat (rand_range(1, 3)) next_cycle();
	endtask

	// the pause lets every byte already sent reach the bus first.
	task automatic pulse_overflow();
		repeat (3) next_cycle();
		sl_overflow = 1'b1;
		next_cycle();
		sl_overflow = 1'b0;
	endtask

	task automatic run_host_frame();
		logic [7:0] addr;
		logic [7:0] evt;
		logic [7:0] payload [MAX_HOST_LEN];
		logic       nak;
		int         len;
		int         kept;
		addr = 8'(rand_range(0, 255));
		evt = 8'(rand_range(0, 255));
		len = rand_range(0, MAX_HOST_LEN);
		nak = (len != 0) && (rand_range(0, 3) == 0);
		kept = nak ? rand_range(0, len - 1) : len;
		for (int i = 0; i < len; i++)
			payload[i] = 8'(rand_range(0, 255));
		// the previous frame has been answered, so its bus frame must be closed.
		check_value("ma_frame_valid before frame", 0, int'(ma_frame_valid));
		expect_host_frame(addr, evt, nak);
		for (int i = 0; i < kept; i++)
			expect_bus_byte(payload[i]);
		send_host_byte(addr);
		send_host_byte(evt);
		send_host_byte(8'(len >> 8));
		send_host_byte(8'(len));
		for (int i = 0; i < len; i++) begin
			if (nak && i == kept)
				pulse_overflow();
			send_host_byte(payload[i]);
		end
		// the framer holds one status, so the pair must go out first.
		while (status_exp.size() != 0)
			next_cycle();
	endtask

	task automatic run_slave_frame(input int index);
		int data_len;
		data_len = rand_range(1, ice_bus_pkg::ICE_MAX_REPLY);
		sl_arb_request[index] = 1'b0;
		expect_slave_frame(index, data_len);
		sl_frame_valid = 1'b1;
		for (int i = 0; i < data_len; i++) begin
			sl_data = 8'(rand_range(0, 255));
			sl_data_valid = 1'b1;
			expect_slave_byte(sl_data);
			next_cycle();
			sl_data_valid = 1'b0;
			if (rand_range(0, 2) == 0)
				next_cycle();
		end
		sl_frame_valid = 1'b0;
		expect_slave_count(data_len);
		next_cycle();
		slave_finished++;
	endtask

	initial begin
		byte_counter_reset = 1'b1;
		rx_char = 8'h00;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b0;
		sl_overflow = 1'b0;
		sl_data = 8'h00;
		sl_arb_request = '0;
		sl_data_valid = 1'b0;
		sl_frame_valid = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		byte_counter_reset = 1'b0;
		check_value("ma_data_valid after reset", 0, int'(ma_data_valid));
		check_value("ma_frame_valid after reset", 0, int'(ma_frame_valid));
		check_value("ma_arb_grant after reset", 0, int'(ma_arb_grant));
		check_value("tx_char_valid after reset", 0, int'(tx_char_valid));
		reset_done = 1'b1;
		for (int h = 0; h < HOST_FRAMES; h++)
			run_host_frame();
		while (slave_finished < SLAVE_FRAMES || status_exp.size() != 0 ||
			slave_exp.size() != 0 || tx_char_valid)
			next_cycle();
		check_value("bus bytes left at end", 0, bus_exp.size());
		$display("Testbench passed");
		$finish;
	end

	// slaves raise requests at random and send a frame once granted.
	initial begin
		int index;
		int grant_exp;
		wait (reset_done);
		while (slave_finished < SLAVE_FRAMES) begin
			if (ma_arb_grant != '0) begin
				grant_exp = expected_grant(sl_arb_request);
				check_value("grant", grant_exp, int'(ma_arb_grant));
				index = 0;
				for (int i = 0; i < ice_bus_pkg::ICE_NUM_DEV; i++)
					if (grant_exp[i])
						index = i;
				run_slave_frame(index);
			end else begin
				for (int i = 0; i < ice_bus_pkg::ICE_NUM_DEV; i++)
					if (!sl_arb_request[i] && slave_requested < SLAVE_FRAMES &&
						rand_range(0, 7) == 0) begin
						sl_arb_request[i] = 1'b1;
						slave_requested++;
					end
				next_cycle();
			end
		end
	end

	initial begin
		int   stretch;
		logic level;
		wait (reset_done);
		forever begin
			stretch = rand_range(1, 24);
			level = (rand_range(0, 2) != 0);
			tx_char_ready = level;
			repeat (stretch) next_cycle();
		end
	end

	always @(posedge clk) begin
		if (reset_done) begin
			if (ma_data_valid && bus_exp.size() == 0) begin
				$display("Bus byte %0h appeared outside any expected frame", ma_data);
				abort_run();
			end else if (ma_data_valid) begin
				check_value("bus frame valid", 1, int'(ma_frame_valid));
				check_value("bus address", int'(bus_addr_exp), int'(ma_addr));
				check_value("bus data", int'(bus_exp.pop_front()), int'(ma_data));
			end
			if (frame_valid_q && !ma_frame_valid)
				check_value("bus bytes missing at frame end", 0, bus_exp.size());
			if (tx_char_valid && tx_char_ready)
				check_tx_byte(tx_char);
		end
		frame_valid_q <= ma_frame_valid;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

endmodule

`default_nettype wire
